/* compile.f */
+incdir+include
rtl/exec_pkg.sv
rtl/div32.sv
rtl/alu.sv
rtl/issue_decode.sv
rtl/hilo_writeback.sv
rtl/exec_cluster.sv
testbench/tb_exec_cluster.sv

/* include/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Instructions accepted per cycle
`define EXEC_LANES 2

// Integer datapath width
`define EXEC_XLEN 32

`endif

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    input  exec_pkg::alu_ctrl_e ctrl,
    output exec_pkg::alu_res_t  res
);

    // Adder
    logic [31:0] add_b;
    logic        carry_in;
    logic [31:0] sum;

    // Logic ops
    logic [31:0] or_out;
    logic [31:0] xor_out;
    logic [31:0] and_out;

    // Shifter and rotators
    logic [4:0]  shamt;
    logic [31:0] sll_out;
    logic [31:0] srl_out;
    logic [31:0] sra_out;
    logic [63:0] rot_right;
    logic [63:0] rot_left;

    // Multiplier
    logic signed [63:0] product;

    // Divider
    logic        a_neg;
    logic        b_neg;
    logic        div_neg;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [31:0] quo_mag;
    logic [31:0] rem_mag;
    logic [31:0] quotient;
    logic [31:0] remainder;

    // Result words
    logic [31:0] hi_w;
    logic [31:0] lo_w;
    logic        neg_w;

    // Subtract as a + ~b + 1
    assign add_b    = (ctrl == exec_pkg::ALU_SUB) ? ~b : b;
    assign carry_in = (ctrl == exec_pkg::ALU_SUB);
    assign sum      = a + add_b + {31'd0, carry_in};

    assign or_out  = a | b;
    assign xor_out = a ^ b;
    assign and_out = a & b;

    assign shamt   = b[4:0];
    assign sll_out = a << shamt;
    assign srl_out = a >> shamt;
    assign sra_out = $signed(a) >>> shamt;

    // Rotate through a doubled copy of a
    assign rot_right = {a, a} >> shamt;
    assign rot_left  = {a, a} << shamt;

    // Operands sign-extended to the full product width
    assign product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});

    // Unsigned divide on magnitudes, signs restored afterwards
    assign a_neg   = a[31];
    assign b_neg   = b[31];
    assign div_neg = a_neg ^ b_neg;
    assign a_mag   = a_neg ? (~a + 32'd1) : a;
    assign b_mag   = b_neg ? (~b + 32'd1) : b;

    div32 u_div (
        .dividend  (a_mag),
        .divisor   (b_mag),
        .quotient  (quo_mag),
        .remainder (rem_mag)
    );

    assign quotient  = div_neg ? (~quo_mag + 32'd1) : quo_mag;
    // remainder follows the dividend's sign
    assign remainder = a_neg ? (~rem_mag + 32'd1) : rem_mag;

    // Hi word only carries data for MUL and DIV
    always_comb begin
        hi_w = '0;
        lo_w = '0;
        case (ctrl)
            exec_pkg::ALU_ADD,
            exec_pkg::ALU_SUB: lo_w = sum;
            exec_pkg::ALU_OR:  lo_w = or_out;
            exec_pkg::ALU_XOR: lo_w = xor_out;
            exec_pkg::ALU_AND: lo_w = and_out;
            exec_pkg::ALU_MUL: begin
                hi_w = product[63:32];
                lo_w = product[31:0];
            end
            exec_pkg::ALU_DIV: begin
                hi_w = quotient;
                lo_w = remainder;
            end
            exec_pkg::ALU_SLL: lo_w = sll_out;
            exec_pkg::ALU_SRL: lo_w = srl_out;
            exec_pkg::ALU_SRA: lo_w = sra_out;
            exec_pkg::ALU_ROR: lo_w = rot_right[31:0];
            exec_pkg::ALU_ROL: lo_w = rot_left[63:32];
            default: ;
        endcase
    end

    always_comb begin
        case (ctrl)
            exec_pkg::ALU_MUL: neg_w = product[63];
            exec_pkg::ALU_DIV: neg_w = div_neg;
            default:           neg_w = lo_w[31];
        endcase
    end

    // Valid is filled in by writeback
    always_comb begin
        res.valid = 1'b0;
        res.ctrl  = ctrl;
        res.hi    = hi_w;
        res.lo    = lo_w;
        res.zero  = ({hi_w, lo_w} == 64'd0);
        res.neg   = neg_w;
    end

endmodule

/* rtl/div32.sv */
`timescale 1ns/1ps

module div32 (
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic [31:0] remainder
);

    // Unrolled restoring division, one quotient bit per step, MSB first
    always_comb begin
        logic [32:0] trial;
        logic [31:0] partial;

        partial  = '0;
        quotient = '0;
        for (int i = 31; i >= 0; i--) begin
            // Shift the next dividend bit into the partial remainder
            trial = {partial, dividend[i]};
            if (trial >= {1'b0, divisor}) begin
                trial       = trial - {1'b0, divisor};
                quotient[i] = 1'b1;
            end
            partial = trial[31:0];
        end
        remainder = partial;
    end

    // A zero divisor passes every compare, so the quotient saturates to
    // all ones and the partial remainder ends as the dividend itself

endmodule

/* rtl/exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_cluster (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  exec_pkg::lane_in_t [`EXEC_LANES-1:0]    bundle,
    output exec_pkg::alu_res_t [`EXEC_LANES-1:0]    result,
    output logic               [`EXEC_LANES-1:0]    illegal,
    output logic               [`EXEC_XLEN-1:0]     hi,
    output logic               [`EXEC_XLEN-1:0]     lo
);

    // Decode stage output, one op per lane
    exec_pkg::alu_op_t  [`EXEC_LANES-1:0] decoded;
    // Combinational ALU results
    exec_pkg::alu_res_t [`EXEC_LANES-1:0] lane_res;

    issue_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .bundle  (bundle),
        .decoded (decoded)
    );

    for (genvar lane = 0; lane < `EXEC_LANES; lane++) begin : g_alu
        alu u_alu (
            .a    (decoded[lane].a),
            .b    (decoded[lane].b),
            .ctrl (decoded[lane].ctrl),
            .res  (lane_res[lane])
        );
    end

    // Result register and HI/LO pair
    hilo_writeback u_writeback (
        .clk      (clk),
        .rst_n    (rst_n),
        .decoded  (decoded),
        .lane_res (lane_res),
        .result   (result),
        .illegal  (illegal),
        .hi       (hi),
        .lo       (lo)
    );

endmodule

/* rtl/exec_pkg.sv */
`include "exec_settings.svh"

package exec_pkg;

    // ALU control codes
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_OR  = 4'h2,
        ALU_XOR = 4'h3,
        ALU_AND = 4'h4,
        ALU_MUL = 4'h5,
        ALU_DIV = 4'h6,
        ALU_SLL = 4'h7,
        ALU_SRL = 4'h8,
        ALU_SRA = 4'h9,
        ALU_ROR = 4'hA,
        ALU_ROL = 4'hB
    } alu_ctrl_e;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_XORI  = 6'h0E;

    // R-format funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ROR  = 6'h0C;
    localparam logic [5:0] FN_ROL  = 6'h0D;
    localparam logic [5:0] FN_MUL  = 6'h18;
    localparam logic [5:0] FN_DIV  = 6'h1A;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same word, two views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        logic                  valid;
        instr_u                instr;
        logic [`EXEC_XLEN-1:0] rs_val;
        logic [`EXEC_XLEN-1:0] rt_val;
    } lane_in_t;

    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_ctrl_e             ctrl;
        logic [`EXEC_XLEN-1:0] a;
        logic [`EXEC_XLEN-1:0] b;
    } alu_op_t;

    typedef struct packed {
        logic                  valid;
        alu_ctrl_e             ctrl;
        logic [`EXEC_XLEN-1:0] hi;
        logic [`EXEC_XLEN-1:0] lo;
        logic                  zero;
        logic                  neg;
    } alu_res_t;

endpackage

/* rtl/hilo_writeback.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module hilo_writeback (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  exec_pkg::alu_op_t  [`EXEC_LANES-1:0]    decoded,
    input  exec_pkg::alu_res_t [`EXEC_LANES-1:0]    lane_res,
    output exec_pkg::alu_res_t [`EXEC_LANES-1:0]    result,
    output logic               [`EXEC_LANES-1:0]    illegal,
    output logic               [`EXEC_XLEN-1:0]     hi,
    output logic               [`EXEC_XLEN-1:0]     lo
);

    exec_pkg::alu_res_t [`EXEC_LANES-1:0] res_q;
    logic [`EXEC_LANES-1:0] res_valid_q;
    logic [`EXEC_LANES-1:0] retire;
    logic [`EXEC_LANES-1:0] lane_illegal;
    logic                   hilo_we;
    logic [`EXEC_XLEN-1:0]  hi_next;
    logic [`EXEC_XLEN-1:0]  lo_next;

    // Scan lanes in order so the later instruction wins HI/LO
    always_comb begin
        hilo_we = 1'b0;
        hi_next = '0;
        lo_next = '0;
        for (int l = 0; l < `EXEC_LANES; l++) begin
            retire[l]       = decoded[l].valid & ~decoded[l].illegal;
            lane_illegal[l] = decoded[l].illegal;
            if (retire[l] && (lane_res[l].ctrl == exec_pkg::ALU_MUL ||
                              lane_res[l].ctrl == exec_pkg::ALU_DIV)) begin
                hilo_we = 1'b1;
                hi_next = lane_res[l].hi;
                lo_next = lane_res[l].lo;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid_q <= '0;
            illegal     <= '0;
            hi          <= '0;
            lo          <= '0;
        end else begin
            res_valid_q <= retire;
            illegal     <= lane_illegal;
            if (hilo_we) begin
                hi <= hi_next;
                lo <= lo_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        res_q <= lane_res;
    end

    // Merge the registered valid into each result
    always_comb begin
        for (int l = 0; l < `EXEC_LANES; l++) begin
            result[l]       = res_q[l];
            result[l].valid = res_valid_q[l];
        end
    end

endmodule

/* rtl/issue_decode.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module issue_decode (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  exec_pkg::lane_in_t [`EXEC_LANES-1:0]    bundle,
    output exec_pkg::alu_op_t  [`EXEC_LANES-1:0]    decoded
);

    for (genvar lane = 0; lane < `EXEC_LANES; lane++) begin : g_lane
        exec_pkg::instr_u      instr;
        exec_pkg::alu_ctrl_e   ctrl_d;
        exec_pkg::alu_ctrl_e   ctrl_q;
        logic [`EXEC_XLEN-1:0] a_d;
        logic [`EXEC_XLEN-1:0] b_d;
        logic [`EXEC_XLEN-1:0] a_q;
        logic [`EXEC_XLEN-1:0] b_q;
        logic                  illegal_d;
        logic                  valid_q;
        logic                  illegal_q;

        assign instr = bundle[lane].instr;

        always_comb begin
            ctrl_d    = exec_pkg::ALU_ADD;
            a_d       = bundle[lane].rs_val;
            b_d       = bundle[lane].rt_val;
            illegal_d = 1'b0;
            if (instr.r_fmt.opcode == exec_pkg::OP_RTYPE) begin
                case (instr.r_fmt.funct)
                    exec_pkg::FN_ADD:  ctrl_d = exec_pkg::ALU_ADD;
                    exec_pkg::FN_SUB:  ctrl_d = exec_pkg::ALU_SUB;
                    exec_pkg::FN_AND:  ctrl_d = exec_pkg::ALU_AND;
                    exec_pkg::FN_OR:   ctrl_d = exec_pkg::ALU_OR;
                    exec_pkg::FN_XOR:  ctrl_d = exec_pkg::ALU_XOR;
                    exec_pkg::FN_MUL:  ctrl_d = exec_pkg::ALU_MUL;
                    exec_pkg::FN_DIV:  ctrl_d = exec_pkg::ALU_DIV;
                    exec_pkg::FN_SLLV: ctrl_d = exec_pkg::ALU_SLL;
                    exec_pkg::FN_SRLV: ctrl_d = exec_pkg::ALU_SRL;
                    exec_pkg::FN_SRAV: ctrl_d = exec_pkg::ALU_SRA;
                    exec_pkg::FN_ROR:  ctrl_d = exec_pkg::ALU_ROR;
                    exec_pkg::FN_ROL:  ctrl_d = exec_pkg::ALU_ROL;
                    // Constant shifts take the amount from the word
                    exec_pkg::FN_SLL: begin
                        ctrl_d = exec_pkg::ALU_SLL;
                        b_d    = {27'd0, instr.r_fmt.shamt};
                    end
                    exec_pkg::FN_SRL: begin
                        ctrl_d = exec_pkg::ALU_SRL;
                        b_d    = {27'd0, instr.r_fmt.shamt};
                    end
                    exec_pkg::FN_SRA: begin
                        ctrl_d = exec_pkg::ALU_SRA;
                        b_d    = {27'd0, instr.r_fmt.shamt};
                    end
                    default: illegal_d = 1'b1;
                endcase
            end else begin
                case (instr.i_fmt.opcode)
                    exec_pkg::OP_ADDI: begin
                        ctrl_d = exec_pkg::ALU_ADD;
                        b_d    = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
                    end
                    exec_pkg::OP_ANDI: begin
                        ctrl_d = exec_pkg::ALU_AND;
                        b_d    = {16'd0, instr.i_fmt.imm};
                    end
                    exec_pkg::OP_ORI: begin
                        ctrl_d = exec_pkg::ALU_OR;
                        b_d    = {16'd0, instr.i_fmt.imm};
                    end
                    exec_pkg::OP_XORI: begin
                        ctrl_d = exec_pkg::ALU_XOR;
                        b_d    = {16'd0, instr.i_fmt.imm};
                    end
                    default: illegal_d = 1'b1;
                endcase
            end
            // Illegal lanes run a harmless 0 + 0
            if (illegal_d) begin
                ctrl_d = exec_pkg::ALU_ADD;
                a_d    = '0;
                b_d    = '0;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_q   <= 1'b0;
                illegal_q <= 1'b0;
            end else begin
                valid_q   <= bundle[lane].valid;
                illegal_q <= bundle[lane].valid & illegal_d;
            end
        end

        always_ff @(posedge clk) begin
            ctrl_q <= ctrl_d;
            a_q    <= a_d;
            b_q    <= b_d;
        end

        assign decoded[lane] = '{valid: valid_q, illegal: illegal_q,
                                 ctrl: ctrl_q, a: a_q, b: b_q};
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_exec_cluster \
    -o sim_exec_cluster

./obj_dir/sim_exec_cluster | tee "$LOG"

if grep -q "Simulation PASSED" "$LOG"; then
    echo "Result: pass"
else
    echo "Result: fail"
    exit 1
fi

/* testbench/tb_exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module tb_exec_cluster;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_ALU_OPS  = 17;
    localparam int ALU_REPS     = 12;
    localparam int MULDIV_REPS  = 6;
    localparam int PAIR_REPS    = 8;
    localparam int ILLEGAL_REPS = 12;
    localparam int STREAM_LEN   = 200;
    localparam int DRAIN_CYCLES = 6;
    // Bundles of all tests plus reset and drains
    localparam int TEST_CYCLES  = 3 + 3 + NUM_ALU_OPS * ALU_REPS + 2 * 4 * MULDIV_REPS + 3
                                + 2 * PAIR_REPS + ILLEGAL_REPS + STREAM_LEN + 6 * DRAIN_CYCLES;
    localparam int MARGIN       = 100;

    // Legal R functs, ALU-only ones first, MUL and DIV last
    localparam logic [5:0]  R_FUNCTS [15] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h00, 6'h02,
                                              6'h03, 6'h04, 6'h06, 6'h07, 6'h0C, 6'h0D, 6'h18,
                                              6'h1A};
    localparam logic [5:0]  I_OPS [4]      = '{6'h08, 6'h0C, 6'h0D, 6'h0E};
    localparam logic [5:0]  BAD_FUNCTS [6] = '{6'h01, 6'h05, 6'h08, 6'h19, 6'h1B, 6'h3F};
    localparam logic [5:0]  BAD_OPS [5]    = '{6'h01, 6'h02, 6'h10, 6'h23, 6'h3F};
    localparam logic [31:0] CORNERS [3]    = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000};
    localparam exec_pkg::lane_in_t IDLE    = '0;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        hilo_we;
        logic [3:0]  ctrl;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        zero;
        logic        neg;
    } lane_exp_t;

    typedef struct packed {
        int                          due;
        lane_exp_t [`EXEC_LANES-1:0] lanes;
        logic [31:0]                 hi;
        logic [31:0]                 lo;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n;
    exec_pkg::lane_in_t [`EXEC_LANES-1:0] bundle;
    exec_pkg::alu_res_t [`EXEC_LANES-1:0] result;
    logic [`EXEC_LANES-1:0] illegal;
    logic [31:0]            hi;
    logic [31:0]            lo;

    exp_t        sb [$];
    logic [31:0] lfsr;
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    int          ticks = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_failed;

    exec_cluster DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .bundle  (bundle),
        .result  (result),
        .illegal (illegal),
        .hi      (hi),
        .lo      (lo)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Register fields are don't-care, so fill them randomly
    function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] shamt);
        logic [31:0] regs;
        regs = rand_bits(15);
        return {6'h00, regs[14:0], shamt, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [15:0] imm);
        logic [31:0] regs;
        regs = rand_bits(10);
        return {op, regs[9:0], imm};
    endfunction

    function automatic exec_pkg::lane_in_t make_lane(input logic v, input logic [31:0] w,
                                                     input logic [31:0] rs,
                                                     input logic [31:0] rt);
        return {v, w, rs, rt};
    endfunction

    function automatic exec_pkg::lane_in_t random_lane();
        logic [31:0] pick;
        logic [31:0] w;
        pick = rand_bits(4);
        if (pick < 9) begin
            w = r_word(R_FUNCTS[int'(rand_bits(4)) % 15], 5'(rand_bits(5)));
        end else if (pick < 14) begin
            w = i_word(I_OPS[int'(rand_bits(2))], 16'(rand_bits(16)));
        end else begin
            w = i_word(BAD_OPS[int'(rand_bits(3)) % 5], 16'(rand_bits(16)));
        end
        return make_lane(rand_bits(1) != 0, w, rand_bits(32), rand_bits(32) >> rand_bits(4));
    endfunction

    // Control code the decode table gives for a word, ADD when illegal
    function automatic logic [3:0] expected_ctrl(input logic [31:0] w);
        logic [3:0] c;
        c = exec_pkg::ALU_ADD;
        if (w[31:26] == 6'h00) begin
            case (w[5:0])
                6'h22:        c = exec_pkg::ALU_SUB;
                6'h24:        c = exec_pkg::ALU_AND;
                6'h25:        c = exec_pkg::ALU_OR;
                6'h26:        c = exec_pkg::ALU_XOR;
                6'h18:        c = exec_pkg::ALU_MUL;
                6'h1A:        c = exec_pkg::ALU_DIV;
                6'h00, 6'h04: c = exec_pkg::ALU_SLL;
                6'h02, 6'h06: c = exec_pkg::ALU_SRL;
                6'h03, 6'h07: c = exec_pkg::ALU_SRA;
                6'h0C:        c = exec_pkg::ALU_ROR;
                6'h0D:        c = exec_pkg::ALU_ROL;
                default: ;
            endcase
        end else begin
            case (w[31:26])
                6'h0C:   c = exec_pkg::ALU_AND;
                6'h0D:   c = exec_pkg::ALU_OR;
                6'h0E:   c = exec_pkg::ALU_XOR;
                default: ;
            endcase
        end
        return c;
    endfunction

    // Reference model of decode plus ALU for one lane
    function automatic lane_exp_t predict(input exec_pkg::lane_in_t in);
        lane_exp_t          e;
        logic [31:0]        w;
        logic [31:0]        ua;
        logic [31:0]        ub;
        logic [4:0]         sh;
        logic [5:0]         back;
        logic signed [63:0] a64;
        logic signed [63:0] b64;
        logic signed [63:0] p64;
        logic               legal;
        logic               wide;
        w     = in.instr;
        ua    = in.rs_val;
        ub    = in.rt_val;
        sh    = ub[4:0];
        back  = 6'd32 - {1'b0, sh};
        a64   = {{32{ua[31]}}, ua};
        b64   = {{32{ub[31]}}, ub};
        legal = 1'b1;
        wide  = 1'b0;
        e     = '0;
        if (w[31:26] == 6'h00) begin
            case (w[5:0])
                6'h20: e.lo = ua + ub;
                6'h22: e.lo = ua - ub;
                6'h24: e.lo = ua & ub;
                6'h25: e.lo = ua | ub;
                6'h26: e.lo = ua ^ ub;
                6'h00: e.lo = ua << w[10:6];
                6'h02: e.lo = ua >> w[10:6];
                6'h03: e.lo = $signed(ua) >>> w[10:6];
                6'h04: e.lo = ua << sh;
                6'h06: e.lo = ua >> sh;
                6'h07: e.lo = $signed(ua) >>> sh;
                6'h0C: e.lo = (ua >> sh) | (ua << back);
                6'h0D: e.lo = (ua << sh) | (ua >> back);
                6'h18: begin
                    wide  = 1'b1;
                    p64   = a64 * b64;
                    e.hi  = p64[63:32];
                    e.lo  = p64[31:0];
                    e.neg = p64[63];
                end
                6'h1A: begin
                    wide  = 1'b1;
                    e.neg = ua[31] ^ ub[31];
                    if (ub == 32'd0) begin
                        // All-ones magnitude, negated for a negative dividend
                        e.hi = ua[31] ? 32'd1 : 32'hFFFF_FFFF;
                        e.lo = ua;
                    end else begin
                        p64  = a64 / b64;
                        e.hi = p64[31:0];
                        p64  = a64 % b64;
                        e.lo = p64[31:0];
                    end
                end
                default: legal = 1'b0;
            endcase
        end else begin
            case (w[31:26])
                6'h08: e.lo = ua + {{16{w[15]}}, w[15:0]};
                6'h0C: e.lo = ua & {16'd0, w[15:0]};
                6'h0D: e.lo = ua | {16'd0, w[15:0]};
                6'h0E: e.lo = ua ^ {16'd0, w[15:0]};
                default: legal = 1'b0;
            endcase
        end
        if (!wide) begin
            e.neg = e.lo[31];
        end
        e.ctrl    = expected_ctrl(w);
        e.zero    = (e.hi == 32'd0) && (e.lo == 32'd0);
        e.valid   = in.valid & legal;
        e.illegal = in.valid & ~legal;
        e.hilo_we = e.valid & wide;
        return e;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // Drive one bundle and queue what should appear two edges later
    task automatic issue(input exec_pkg::lane_in_t l0, input exec_pkg::lane_in_t l1);
        exp_t e;
        @(posedge clk);
        bundle[0] <= l0;
        bundle[1] <= l1;
        e.due      = ticks + 3;
        e.lanes[0] = predict(l0);
        e.lanes[1] = predict(l1);
        // Later lane overwrites HI/LO
        for (int l = 0; l < `EXEC_LANES; l++) begin
            if (e.lanes[l].hilo_we) begin
                model_hi = e.lanes[l].hi;
                model_lo = e.lanes[l].lo;
            end
        end
        e.hi = model_hi;
        e.lo = model_lo;
        sb.push_back(e);
    endtask

    task automatic drain();
        issue(IDLE, IDLE);
        while (sb.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    // Outputs are compared on the falling edge, away from the drive edge
    always @(negedge clk) begin
        exp_t e;
        ticks = ticks + 1;
        // Everything stays cleared while reset is held
        if (!rst_n) begin
            for (int l = 0; l < `EXEC_LANES; l++) begin
                check_word($sformatf("result[%0d].valid", l), 32'(result[l].valid), 32'd0);
                check_word($sformatf("illegal[%0d]", l), 32'(illegal[l]), 32'd0);
            end
            check_word("hi", hi, 32'd0);
            check_word("lo", lo, 32'd0);
        end
        if (sb.size() > 0 && sb[0].due == ticks) begin
            e = sb.pop_front();
            for (int l = 0; l < `EXEC_LANES; l++) begin
                check_word($sformatf("result[%0d].valid", l), 32'(result[l].valid),
                           32'(e.lanes[l].valid));
                check_word($sformatf("illegal[%0d]", l), 32'(illegal[l]),
                           32'(e.lanes[l].illegal));
                // Illegal lanes run 0 + 0, so their data is defined too
                if (e.lanes[l].valid || e.lanes[l].illegal) begin
                    check_word($sformatf("result[%0d].ctrl", l), 32'(result[l].ctrl),
                               32'(e.lanes[l].ctrl));
                    check_word($sformatf("result[%0d].hi", l), result[l].hi, e.lanes[l].hi);
                    check_word($sformatf("result[%0d].lo", l), result[l].lo, e.lanes[l].lo);
                    check_word($sformatf("result[%0d].zero", l), 32'(result[l].zero),
                               32'(e.lanes[l].zero));
                    check_word($sformatf("result[%0d].neg", l), 32'(result[l].neg),
                               32'(e.lanes[l].neg));
                end
            end
            check_word("hi", hi, e.hi);
            check_word("lo", lo, e.lo);
        end
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
        $display("Watchdog expired: tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [4:0]  sh;
        int          start_errors;

        lfsr         = 32'hceb5_6618;
        model_hi     = '0;
        model_lo     = '0;
        tests_failed = 0;
        // Valid MUL and DIV traffic waits at the inputs during reset
        bundle[0]    = make_lane(1'b1, r_word(6'h18, 5'd0), 32'h1234_5678, 32'h9abc_def0);
        bundle[1]    = make_lane(1'b1, r_word(6'h1A, 5'd0), 32'hfedc_ba98, 32'h0000_0013);
        rst_n        = 1'b0;
        start_errors = errors;
        repeat (3) @(posedge clk);
        rst_n  <= 1'b1;
        bundle <= '0;

        repeat (3) issue(IDLE, IDLE);
        drain();
        report_test("reset_idle", start_errors);

        // Corner operand pairs first, then random ones
        start_errors = errors;
        for (int k = 0; k < NUM_ALU_OPS; k++) begin
            for (int i = 0; i < ALU_REPS; i++) begin
                if (i < 9) begin
                    a  = CORNERS[i / 3];
                    b  = CORNERS[i % 3];
                    sh = (i % 2 == 1) ? 5'd31 : 5'd0;
                end else begin
                    a  = rand_bits(32);
                    b  = rand_bits(32);
                    sh = 5'(rand_bits(5));
                end
                if (k < 13) begin
                    w0 = r_word(R_FUNCTS[k], sh);
                end else begin
                    w0 = i_word(I_OPS[k - 13], b[15:0]);
                end
                issue(make_lane(1'b1, w0, a, b), make_lane(1'b1, w0, b, a));
            end
        end
        drain();
        report_test("alu_ops", start_errors);

        start_errors = errors;
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 4 * MULDIV_REPS; i++) begin
                ma = rand_bits(31);
                mb = rand_bits(16);
                a  = i[0] ? -ma : ma;
                b  = i[1] ? -mb : mb;
                w0 = r_word((k == 0) ? 6'h18 : 6'h1A, 5'd0);
                issue(make_lane(1'b1, w0, a, b), IDLE);
            end
        end
        issue(make_lane(1'b1, r_word(6'h1A, 5'd0), 32'd1234, 32'd0), IDLE);
        issue(make_lane(1'b1, r_word(6'h1A, 5'd0), 32'hFFFF_F000, 32'd0), IDLE);
        issue(make_lane(1'b1, r_word(6'h1A, 5'd0), 32'h8000_0000, 32'hFFFF_FFFF), IDLE);
        drain();
        report_test("mul_div", start_errors);

        start_errors = errors;
        for (int i = 0; i < PAIR_REPS; i++) begin
            w0 = r_word(i[0] ? 6'h1A : 6'h18, 5'd0);
            w1 = r_word(i[1] ? 6'h1A : 6'h18, 5'd0);
            issue(make_lane(1'b1, w0, rand_bits(32), rand_bits(32) >> 8),
                  make_lane(1'b1, w1, rand_bits(32), rand_bits(32) >> 8));
            // ALU-only bundle leaves HI/LO alone
            issue(make_lane(1'b1, r_word(6'h20, 5'd0), rand_bits(32), rand_bits(32)),
                  make_lane(1'b1, i_word(6'h0D, 16'(rand_bits(16))), rand_bits(32),
                            rand_bits(32)));
        end
        drain();
        report_test("hilo_priority", start_errors);

        start_errors = errors;
        for (int i = 0; i < ILLEGAL_REPS; i++) begin
            w0 = r_word(BAD_FUNCTS[i % 6], 5'(rand_bits(5)));
            w1 = i_word(BAD_OPS[i % 5], 16'(rand_bits(16)));
            issue(make_lane(1'b1, w0, rand_bits(32), rand_bits(32)),
                  make_lane(i % 3 != 0, w1, rand_bits(32), rand_bits(32)));
        end
        drain();
        report_test("illegal", start_errors);

        start_errors = errors;
        for (int i = 0; i < STREAM_LEN; i++) begin
            issue(random_lane(), random_lane());
        end
        drain();
        report_test("back_to_back", start_errors);

        $display("Tests: 6 run, %0d failed; checks: %0d, errors: %0d",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
